/* src.f */
+incdir+src
src/core_pkg.sv
src/free_list.sv
src/rename_stage.sv
src/reorder_buffer.sv
src/phys_regfile.sv
src/issue_stage.sv
src/alu_stage.sv
src/ooo_core_top.sv
dv/core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

export_include_dirs:
  - src

sources:
  - src/core_pkg.sv
  - src/free_list.sv
  - src/rename_stage.sv
  - src/reorder_buffer.sv
  - src/phys_regfile.sv
  - src/issue_stage.sv
  - src/alu_stage.sv
  - src/ooo_core_top.sv
  - target: test
    files:
      - dv/core_tb.sv

/* dv/core_tb.sv */
// testbench for the one-wide core
// clock, reset, architectural reference model, retire monitor, directed tests
`timescale 1ns/100ps
`include "core_config.svh"

module core_tb;

    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam int         TIMEOUT_CYCLES = 4000;  // ~4x the random test
    localparam int         DRAIN_CYCLES   = 200;   // ample for a full rob to retire

    logic        clock;
    logic        arst_n;
    logic        inst_valid;
    logic [31:0] inst_word;
    logic        inst_ready;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;
    logic        retire_ready;

    logic [31:0] arch_regs [32];  // x0 stays zero
    logic [4:0]  exp_rd [$];      // filled at accept, popped at retire
    logic [31:0] exp_val [$];
    logic [4:0]  got_rd;
    logic [31:0] got_val;
    int          retire_mode;     // 0 ready, 1 stalled, 2 random
    int          cycle_count;

    ooo_core_top u_ooo_core_top (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    ////////////////////////////////////////
    // checking
    ////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: actual 0x%08h expected 0x%08h", name, actual, expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // retire handshake seen mid-cycle, transfers on the next rising edge
    always @(negedge clock) begin
        if (arst_n && retire_valid && retire_ready) begin
            if (exp_rd.size() == 0) begin
                $display("a retirement came out with no instruction outstanding");
                $display("TEST FAIL");
                $fatal(1);
            end else begin
                got_rd  = exp_rd.pop_front();
                got_val = exp_val.pop_front();
                check_value("retire_rd", 32'(retire_rd), 32'(got_rd));
                check_value("retire_value", retire_value, got_val);
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the core stopped making progress", cycle_count);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    // retire_ready driven just after the edge
    always begin
        @(posedge clock);
        #1;
        case (retire_mode)
            0:       retire_ready = 1'b1;
            1:       retire_ready = 1'b0;
            default: retire_ready = ($urandom_range(0, 3) != 0);  // 75% ready
        endcase
    end

    ////////////////////////////////////////
    // reference model and stimulus helpers
    ////////////////////////////////////////
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    // applies one accepted instruction in program order, queues its retirement
    task automatic apply_model(input logic [31:0] w);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        ok;
        rd  = w[11:7];
        f3  = w[14:12];
        f7  = w[31:25];
        a   = arch_regs[w[19:15]];
        b   = (w[6:0] == OPC_IMM) ? {{20{w[31]}}, w[31:20]} : arch_regs[w[24:20]];
        ok  = (w[6:0] == OPC_REG) || (w[6:0] == OPC_IMM);
        res = '0;
        case (f3)
            3'b000: res = (w[6:0] == OPC_REG && f7 == 7'h20) ? a - b : a + b;
            3'b100: res = a ^ b;
            3'b110: res = a | b;
            3'b111: res = a & b;
            default: ok = 1'b0;  // shifts, compares
        endcase
        if (w[6:0] == OPC_REG && f7 != 7'h00 && !(f7 == 7'h20 && f3 == 3'b000)) begin
            ok = 1'b0;  // bad funct7
        end
        if (ok && rd != 5'd0) begin
            arch_regs[rd] = res;
            exp_rd.push_back(rd);
            exp_val.push_back(res);
        end else begin
            exp_rd.push_back(5'd0);  // no write retires as x0, zero
            exp_val.push_back('0);
        end
    endtask

    // holds inst_valid until the handshake, leaves aligned 1 ns after an edge
    task automatic send_inst(input logic [31:0] w);
        logic taken;
        taken      = 1'b0;
        inst_valid = 1'b1;
        inst_word  = w;
        while (!taken) begin
            @(negedge clock);
            if (inst_ready) begin
                apply_model(w);
                taken = 1'b1;
            end
            @(posedge clock);
            #1;
        end
        inst_valid = 1'b0;
    endtask

    task automatic wait_retired();
        while (exp_rd.size() != 0) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic set_retire_mode(input int mode);
        @(negedge clock);
        retire_mode = mode;
        @(posedge clock);
        #1;
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_reset_and_first_addi();
        @(negedge clock);
        check_value("retire_valid", 32'(retire_valid), 32'd0);
        check_value("inst_ready", 32'(inst_ready), 32'd1);
        @(posedge clock);
        #1;
        send_inst(enc_i(12'h2a5, 5'd0, 3'b000, 5'd1));  // addi x1, x0, 0x2a5
        wait_retired();
    endtask

    task automatic test_all_ops();
        send_inst(enc_i(12'h7ff, 5'd0, 3'b000, 5'd2));          // addi
        send_inst(enc_i(12'h800, 5'd0, 3'b000, 5'd3));          // addi, negative
        send_inst(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));      // add
        send_inst(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd5));      // sub
        send_inst(enc_r(7'h00, 5'd3, 5'd1, 3'b111, 5'd6));      // and
        send_inst(enc_r(7'h00, 5'd3, 5'd2, 3'b110, 5'd7));      // or
        send_inst(enc_r(7'h00, 5'd3, 5'd1, 3'b100, 5'd8));      // xor
        send_inst(enc_i(12'h0f0, 5'd1, 3'b111, 5'd9));          // andi
        send_inst(enc_i(12'h90a, 5'd2, 3'b110, 5'd10));         // ori
        send_inst(enc_i(12'hfff, 5'd1, 3'b100, 5'd11));         // xori, not
        wait_retired();
    endtask

    task automatic test_dependent_chain();
        send_inst(enc_i(12'h003, 5'd0, 3'b000, 5'd12));
        for (int i = 0; i < 8; i++) begin
            send_inst(enc_r(7'h00, 5'd12, 5'd12, 3'b000, 5'd12));  // x12 doubles
        end
        send_inst(enc_r(7'h20, 5'd1, 5'd12, 3'b000, 5'd13));
        send_inst(enc_i(12'h155, 5'd13, 3'b100, 5'd13));
        send_inst(enc_r(7'h00, 5'd13, 5'd12, 3'b110, 5'd12));
        wait_retired();
    endtask

    task automatic test_no_write_cases();
        send_inst(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));  // add into x0
        send_inst({12'h010, 5'd1, 3'b010, 5'd5, 7'b0000011});  // load, not kept
        send_inst(enc_i(12'h000, 5'd5, 3'b000, 5'd14));     // x5 must be unchanged
        wait_retired();
    endtask

    task automatic test_rob_backpressure();
        int accepted;
        accepted = 0;
        set_retire_mode(1);
        inst_valid = 1'b1;
        inst_word  = enc_i(12'h011, 5'd0, 3'b000, 5'd16);
        for (int c = 0; c < 24; c++) begin
            @(negedge clock);
            if (inst_ready) begin
                apply_model(inst_word);
                accepted++;
            end
            @(posedge clock);
            #1;
            inst_word = enc_i(12'(17 * (accepted + 1)), 5'd0, 3'b000, 5'(16 + accepted));
        end
        inst_valid = 1'b0;
        check_value("accepted", 32'(accepted), 32'(`CORE_ROB_DEPTH));
        @(negedge clock);
        check_value("inst_ready", 32'(inst_ready), 32'd0);
        check_value("retire_valid", 32'(retire_valid), 32'd1);  // head done, held
        set_retire_mode(0);
        wait_retired();
    endtask

    // leaves the last instructions in flight, drained at the end of the run
    task automatic test_random_mix();
        logic [31:0] w;
        int          sel;
        set_retire_mode(2);
        for (int n = 0; n < 200; n++) begin
            repeat ($urandom_range(0, 2)) begin
                @(posedge clock);
                #1;
            end
            w   = $urandom;
            sel = $urandom_range(0, 7);
            if (sel < 4) begin
                w[6:0] = OPC_REG;
                if (sel < 3) begin
                    w[31:25] = (sel == 0) ? 7'h20 : 7'h00;  // sel 3 keeps a raw funct7
                end
            end else if (sel < 7) begin
                w[6:0] = OPC_IMM;
            end
            send_inst(w);  // sel 7, random opcode
        end
        set_retire_mode(0);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        void'($urandom(32'h995e));
        arst_n       = 1'b0;
        inst_valid   = 1'b0;
        inst_word    = '0;
        retire_ready = 1'b1;
        retire_mode  = 0;
        cycle_count  = 0;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end
        repeat (3) @(posedge clock);
        #1;
        arst_n = 1'b1;

        test_reset_and_first_addi();
        test_all_ops();
        test_dependent_chain();
        test_no_write_cases();
        test_rob_backpressure();
        test_random_mix();

        // bounded drain of whatever is still in flight
        for (int c = 0; c < DRAIN_CYCLES && exp_rd.size() != 0; c++) begin
            @(posedge clock);
            #1;
        end
        @(negedge clock);
        if (exp_rd.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("%0d accepted instructions never retired", exp_rd.size());
            $display("TEST FAIL");
            $fatal(1);
        end
    end

endmodule

/* src/ooo_core_top.sv */
// top level of the one-wide core
// rename, free list, issue, register file, alu and rob
`timescale 1ns/100ps

module ooo_core_top (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              inst_valid,
    input  core_pkg::inst_t   inst_word,
    output logic              inst_ready,
    output logic              retire_valid,
    output core_pkg::ar_idx_t retire_rd,
    output core_pkg::word_t   retire_value,
    input  logic              retire_ready
);
    import core_pkg::*;

    ////////////////////////////////////////
    // rename, free list, rob allocation
    ////////////////////////////////////////
    logic      free_valid;
    pr_idx_t   free_pr;
    logic      fl_pop;
    logic      fl_push;
    pr_idx_t   fl_push_pr;
    logic      rob_full;
    rob_idx_t  rob_tail;
    logic      rob_alloc;
    ar_idx_t   alloc_rd;
    pr_idx_t   alloc_new_pr;
    pr_idx_t   alloc_old_pr;

    // rename -> issue
    logic      ren_valid;
    logic      ren_ready;
    pr_idx_t   ren_rs1_pr;
    pr_idx_t   ren_rs2_pr;
    pr_idx_t   ren_dst_pr;
    logic      ren_dest_write;
    rob_idx_t  ren_rob;
    alu_op_e   ren_op;
    word_t     ren_imm;
    logic      ren_use_imm;

    // issue <-> register file
    pr_idx_t   rd1_pr;
    pr_idx_t   rd2_pr;
    word_t     rd1_value;
    logic      rd1_ready;
    word_t     rd2_value;
    logic      rd2_ready;

    // issue -> alu
    logic      exe_valid;
    word_t     exe_a;
    word_t     exe_b;
    alu_op_e   exe_op;
    pr_idx_t   exe_dst_pr;
    logic      exe_dest_write;
    rob_idx_t  exe_rob;

    // writeback and completion
    logic      wb_en;
    pr_idx_t   wb_pr;
    word_t     wb_value;
    logic      cmp_valid;
    rob_idx_t  cmp_rob;
    word_t     cmp_value;

    ////////////////////////////////////////
    // stages, port names match the wires
    ////////////////////////////////////////
    rename_stage   u_rename_stage   (.*);
    free_list      u_free_list      (.*);
    issue_stage    u_issue_stage    (.*);
    alu_stage      u_alu_stage      (.*);
    reorder_buffer u_reorder_buffer (.*);

    phys_regfile u_phys_regfile (
        .*,
        .clr_en (fl_pop),   // new destination not ready until written
        .clr_pr (free_pr)
    );

endmodule

/* src/alu_stage.sv */
// alu stage: computes the op, registers the result,
// writes back to the register file and completes in the rob
`timescale 1ns/100ps

module alu_stage (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               exe_valid,
    input  core_pkg::word_t    exe_a,
    input  core_pkg::word_t    exe_b,     // rs2 or immediate
    input  core_pkg::alu_op_e  exe_op,
    input  core_pkg::pr_idx_t  exe_dst_pr,
    input  logic               exe_dest_write,
    input  core_pkg::rob_idx_t exe_rob,
    output logic               wb_en,
    output core_pkg::pr_idx_t  wb_pr,
    output core_pkg::word_t    wb_value,
    output logic               cmp_valid,
    output core_pkg::rob_idx_t cmp_rob,
    output core_pkg::word_t    cmp_value
);
    import core_pkg::*;

    word_t result;
    word_t result_q;

    always_comb begin
        case (exe_op)
            ALU_ADD: result = exe_a + exe_b;
            ALU_SUB: result = exe_a - exe_b;
            ALU_AND: result = exe_a & exe_b;
            ALU_OR:  result = exe_a | exe_b;
            ALU_XOR: result = exe_a ^ exe_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wb_en     <= 1'b0;
            cmp_valid <= 1'b0;
        end else begin
            wb_en     <= exe_valid && exe_dest_write;
            cmp_valid <= exe_valid;  // every op completes, even no-write ones
        end
    end

    always_ff @(posedge clock) begin
        if (exe_valid) begin
            result_q <= result;
            wb_pr    <= exe_dst_pr;
            cmp_rob  <= exe_rob;
        end
    end

    // one result register feeds both writeback paths
    assign wb_value  = result_q;
    assign cmp_value = result_q;

endmodule

/* src/issue_stage.sv */
// issue stage: one-entry holding register, waits for ready sources
// then fires into the alu in program order
`timescale 1ns/100ps

module issue_stage (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               ren_valid,
    input  core_pkg::pr_idx_t  ren_rs1_pr,
    input  core_pkg::pr_idx_t  ren_rs2_pr,
    input  core_pkg::pr_idx_t  ren_dst_pr,
    input  logic               ren_dest_write,
    input  core_pkg::rob_idx_t ren_rob,
    input  core_pkg::alu_op_e  ren_op,
    input  core_pkg::word_t    ren_imm,
    input  logic               ren_use_imm,
    output logic               ren_ready,
    output core_pkg::pr_idx_t  rd1_pr,
    output core_pkg::pr_idx_t  rd2_pr,
    input  core_pkg::word_t    rd1_value,
    input  logic               rd1_ready,
    input  core_pkg::word_t    rd2_value,
    input  logic               rd2_ready,
    output logic               exe_valid,
    output core_pkg::word_t    exe_a,
    output core_pkg::word_t    exe_b,
    output core_pkg::alu_op_e  exe_op,
    output core_pkg::pr_idx_t  exe_dst_pr,
    output logic               exe_dest_write,
    output core_pkg::rob_idx_t exe_rob
);
    import core_pkg::*;

    logic       iss_valid;
    logic       load;
    logic       fire;
    pr_idx_t    iss_rs1_pr;
    pr_idx_t    iss_rs2_pr;
    word_t      iss_imm;
    logic       iss_use_imm;

    assign rd1_pr = iss_rs1_pr;  // register file lookups
    assign rd2_pr = iss_rs2_pr;

    // second source unused under an immediate
    assign fire      = iss_valid && rd1_ready && (iss_use_imm || rd2_ready);
    assign ren_ready = !iss_valid || fire;
    assign load      = ren_valid && ren_ready;

    assign exe_valid = fire;
    assign exe_a     = rd1_value;
    assign exe_b     = iss_use_imm ? iss_imm : rd2_value;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            iss_valid <= 1'b0;
        end else if (load) begin
            iss_valid <= 1'b1;
        end else if (fire) begin
            iss_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            iss_rs1_pr     <= ren_rs1_pr;
            iss_rs2_pr     <= ren_rs2_pr;
            iss_imm        <= ren_imm;
            iss_use_imm    <= ren_use_imm;
            exe_op         <= ren_op;
            exe_dst_pr     <= ren_dst_pr;
            exe_dest_write <= ren_dest_write;
            exe_rob        <= ren_rob;
        end
    end

endmodule

/* src/phys_regfile.sv */
// physical register file with ready bits
// two combinational reads, one writeback, ready clear on allocation
`timescale 1ns/100ps
`include "core_config.svh"

module phys_regfile (
    input  logic              clock,
    input  logic              arst_n,
    input  core_pkg::pr_idx_t rd1_pr,
    input  core_pkg::pr_idx_t rd2_pr,
    output core_pkg::word_t   rd1_value,
    output logic              rd1_ready,
    output core_pkg::word_t   rd2_value,
    output logic              rd2_ready,
    input  logic              wb_en,     // from alu, sets ready
    input  core_pkg::pr_idx_t wb_pr,
    input  core_pkg::word_t   wb_value,
    input  logic              clr_en,    // rename allocated a register
    input  core_pkg::pr_idx_t clr_pr
);
    import core_pkg::*;

    word_t  regs  [`CORE_NUM_PR];
    logic   ready [`CORE_NUM_PR];

    // no bypass, a write shows after the edge
    assign rd1_value = regs[rd1_pr];
    assign rd1_ready = ready[rd1_pr];
    assign rd2_value = regs[rd2_pr];
    assign rd2_ready = ready[rd2_pr];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CORE_NUM_PR; i++) begin
                regs[i]  <= '0;
                ready[i] <= (i < `CORE_NUM_AR);  // identity-mapped, zero valued
            end
        end else begin
            if (clr_en) begin
                ready[clr_pr] <= 1'b0;
            end
            if (wb_en) begin
                regs[wb_pr]  <= wb_value;
                ready[wb_pr] <= 1'b1;  // free regs never written, no clash with clr
            end
        end
    end

endmodule

/* src/reorder_buffer.sv */
// reorder buffer: in-order entry queue, completion marking,
// retire port and return of replaced registers to the free list
`timescale 1ns/100ps
`include "core_config.svh"

module reorder_buffer (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               rob_alloc,
    input  core_pkg::ar_idx_t  alloc_rd,
    input  core_pkg::pr_idx_t  alloc_new_pr,
    input  core_pkg::pr_idx_t  alloc_old_pr,
    output logic               rob_full,
    output core_pkg::rob_idx_t rob_tail,
    input  logic               cmp_valid,
    input  core_pkg::rob_idx_t cmp_rob,
    input  core_pkg::word_t    cmp_value,
    output logic               fl_push,
    output core_pkg::pr_idx_t  fl_push_pr,
    output logic               retire_valid,
    output core_pkg::ar_idx_t  retire_rd,
    output core_pkg::word_t    retire_value,
    input  logic               retire_ready
);
    import core_pkg::*;

    localparam int DEPTH = `CORE_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    // entry fields
    logic       done   [DEPTH];
    ar_idx_t    rd_q   [DEPTH];
    pr_idx_t    new_pr [DEPTH];
    pr_idx_t    old_pr [DEPTH];
    word_t      value  [DEPTH];

    rob_idx_t   head;
    rob_idx_t   tail;
    logic [CNT_W-1:0] count;
    logic       head_wrote;
    logic       retire;

    assign rob_full = (count == DEPTH[CNT_W-1:0]);
    assign rob_tail = tail;

    ////////////////////////////////////////
    // retire side
    ////////////////////////////////////////
    assign retire_valid = (count != '0) && done[head];
    assign retire       = retire_valid && retire_ready;
    // a renamed entry never keeps the mapping it replaced
    assign head_wrote   = (new_pr[head] != old_pr[head]);
    assign retire_rd    = head_wrote ? rd_q[head] : '0;
    assign retire_value = head_wrote ? value[head] : '0;
    assign fl_push      = retire && head_wrote;
    assign fl_push_pr   = old_pr[head];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            if (cmp_valid) begin
                done[cmp_rob] <= 1'b1;
            end
            if (rob_alloc) begin
                done[tail] <= 1'b0;  // tail slot is free, never the cmp target
                tail       <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + rob_alloc - retire;
        end
    end

    // entry payload
    always_ff @(posedge clock) begin
        if (rob_alloc) begin
            rd_q[tail]   <= alloc_rd;
            new_pr[tail] <= alloc_new_pr;
            old_pr[tail] <= alloc_old_pr;
        end
        if (cmp_valid) begin
            value[cmp_rob] <= cmp_value;
        end
    end

endmodule

/* src/rename_stage.sv */
// rename stage: decode, map table, free register and rob allocation,
// output register toward issue
`timescale 1ns/100ps
`include "core_config.svh"

module rename_stage (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               inst_valid,
    input  core_pkg::inst_t    inst_word,
    output logic               inst_ready,
    input  logic               free_valid,
    input  core_pkg::pr_idx_t  free_pr,
    output logic               fl_pop,
    input  logic               rob_full,
    input  core_pkg::rob_idx_t rob_tail,
    output logic               rob_alloc,
    output core_pkg::ar_idx_t  alloc_rd,
    output core_pkg::pr_idx_t  alloc_new_pr,
    output core_pkg::pr_idx_t  alloc_old_pr,
    output logic               ren_valid,
    input  logic               ren_ready,
    output core_pkg::pr_idx_t  ren_rs1_pr,
    output core_pkg::pr_idx_t  ren_rs2_pr,
    output core_pkg::pr_idx_t  ren_dst_pr,
    output logic               ren_dest_write,
    output core_pkg::rob_idx_t ren_rob,
    output core_pkg::alu_op_e  ren_op,
    output core_pkg::word_t    ren_imm,
    output logic               ren_use_imm
);
    import core_pkg::*;

    pr_idx_t    map_table [`CORE_NUM_AR];  // arch -> phys, speculative

    logic       is_reg;
    logic       is_imm;
    logic       f3_ok;
    logic       f7_ok;
    logic       dest_write;
    logic       accept;
    logic [2:0] funct3;
    ar_idx_t    rs1;
    ar_idx_t    rs2;
    ar_idx_t    rd;
    alu_op_e    op;
    word_t      imm;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    assign is_reg = (inst_word.r_fmt.opcode == OP_REG);
    assign is_imm = (inst_word.i_fmt.opcode == OP_IMM);

    always_comb begin
        rs2   = '0;  // x0 maps to p0, always ready
        imm   = '0;
        f7_ok = 1'b1;
        if (is_imm) begin
            rs1    = inst_word.i_fmt.rs1;
            rd     = inst_word.i_fmt.rd;
            funct3 = inst_word.i_fmt.funct3;
            imm    = {{(`CORE_XLEN-12){inst_word.i_fmt.imm[11]}}, inst_word.i_fmt.imm};
        end else begin
            rs1    = inst_word.r_fmt.rs1;
            rs2    = inst_word.r_fmt.rs2;
            rd     = inst_word.r_fmt.rd;
            funct3 = inst_word.r_fmt.funct3;
            f7_ok  = (inst_word.r_fmt.funct7 == F7_BASE) ||
                     (inst_word.r_fmt.funct7 == F7_SUB && funct3 == F3_ADD);
        end
        f3_ok = 1'b1;
        case (funct3)
            F3_ADD:  op = (!is_imm && inst_word.r_fmt.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
            F3_XOR:  op = ALU_XOR;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: begin
                op    = ALU_ADD;
                f3_ok = 1'b0;  // shifts and compares not kept
            end
        endcase
    end

    // unsupported or x0 destination: passes through, writes nothing
    assign dest_write = (is_reg || is_imm) && f3_ok && f7_ok && (rd != '0);

    ////////////////////////////////////////
    // accept and allocation
    ////////////////////////////////////////
    assign inst_ready   = (!ren_valid || ren_ready) && !rob_full && free_valid;
    assign accept       = inst_valid && inst_ready;
    assign fl_pop       = accept && dest_write;
    assign rob_alloc    = accept;
    assign alloc_rd     = rd;
    assign alloc_old_pr = map_table[rd];
    assign alloc_new_pr = dest_write ? free_pr : map_table[rd];  // same as old if no rename

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ren_valid <= 1'b0;
            for (int i = 0; i < `CORE_NUM_AR; i++) begin
                map_table[i] <= pr_idx_t'(i);  // identity
            end
        end else begin
            if (accept) begin
                ren_valid <= 1'b1;
            end else if (ren_ready) begin
                ren_valid <= 1'b0;
            end
            if (fl_pop) begin
                map_table[rd] <= free_pr;
            end
        end
    end

    // sources read the map before this instruction's own update
    always_ff @(posedge clock) begin
        if (accept) begin
            ren_rs1_pr     <= map_table[rs1];
            ren_rs2_pr     <= map_table[rs2];
            ren_dst_pr     <= free_pr;
            ren_dest_write <= dest_write;
            ren_rob        <= rob_tail;
            ren_op         <= op;
            ren_imm        <= imm;
            ren_use_imm    <= is_imm;
        end
    end

endmodule

/* src/free_list.sv */
// free list of unmapped physical registers
// circular queue, popped by rename, pushed at retire
`timescale 1ns/100ps
`include "core_config.svh"

module free_list (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              fl_pop,      // rename takes free_pr
    input  logic              fl_push,     // retire returns an old mapping
    input  core_pkg::pr_idx_t fl_push_pr,
    output logic              free_valid,
    output core_pkg::pr_idx_t free_pr
);
    import core_pkg::*;

    localparam int FL_DEPTH = `CORE_NUM_PR - `CORE_NUM_AR;
    localparam int FL_IDX_W = $clog2(FL_DEPTH);

    pr_idx_t             fl_mem [FL_DEPTH];
    logic [FL_IDX_W-1:0] head;
    logic [FL_IDX_W-1:0] tail;
    logic [FL_IDX_W:0]   count;

    assign free_valid = (count != '0);
    assign free_pr    = fl_mem[head];  // next register handed out

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= pr_idx_t'(`CORE_NUM_AR + i);  // 32 upward
            end
            head  <= '0;
            tail  <= '0;  // full, tail sits on head
            count <= FL_DEPTH[FL_IDX_W:0];
        end else begin
            if (fl_push) begin
                fl_mem[tail] <= fl_push_pr;
                tail         <= tail + 1'b1;  // power-of-two depth wraps
            end
            if (fl_pop) begin
                head <= head + 1'b1;
            end
            case ({fl_push, fl_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together
            endcase
        end
    end

endmodule

/* src/core_pkg.sv */
// core types: instruction word views, opcodes, function codes,
// alu ops, register and rob index types
`include "core_config.svh"

package core_pkg;

    typedef logic [$clog2(`CORE_NUM_AR)-1:0]    ar_idx_t;   // 5 bits
    typedef logic [$clog2(`CORE_NUM_PR)-1:0]    pr_idx_t;   // 6 bits
    typedef logic [$clog2(`CORE_ROB_DEPTH)-1:0] rob_idx_t;  // 3 bits
    typedef logic [`CORE_XLEN-1:0]              word_t;

    // major opcodes the alu takes
    typedef enum logic [6:0] {
        OP_REG = 7'b0110011,  // add sub and or xor
        OP_IMM = 7'b0010011   // addi andi ori xori
    } opcode_e;

    // funct3 / funct7 codes of the kept ops
    localparam logic [2:0] F3_ADD  = 3'b000;  // also sub
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    ////////////////////////////////////////
    // one instruction word, two decodings
    ////////////////////////////////////////
    typedef union packed {
        struct packed {
            logic [6:0]  funct7;
            ar_idx_t     rs2;
            ar_idx_t     rs1;
            logic [2:0]  funct3;
            ar_idx_t     rd;
            logic [6:0]  opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;      // sign extended at rename
            ar_idx_t     rs1;
            logic [2:0]  funct3;
            ar_idx_t     rd;
            logic [6:0]  opcode;
        } i_fmt;
    } inst_t;

endpackage

/* src/core_config.svh */
// core sizes
// data width, register counts, reorder-buffer depth
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath width
`define CORE_XLEN       32

// register counts
`define CORE_NUM_AR     32  // x0..x31
`define CORE_NUM_PR     48  // 16 spare for renaming

// in-flight window, one entry per instruction in the core
`define CORE_ROB_DEPTH  8

`endif
